// ==== filelist.f ====
common/ccl_frame_pkg.sv
common/ccl_region_pkg.sv
rtl/frame_timing.sv
labeling/line_label_buffer.sv
labeling/label_assigner.sv
rtl/region_accumulator.sv
rtl/centroid_reporter.sv
rtl/ccl_centroid.sv
bench/tb_clock.sv
bench/ccl_checker.sv
bench/ccl_props.sv
bench/tb_ccl.sv

// ==== bench/tb_ccl.sv ====
`timescale 1ns/1ps

module tb_ccl;

    localparam int w         = ccl_frame_pkg::img_width;
    localparam int h         = ccl_frame_pkg::img_height;
    localparam int line_gap  = 3;           // idle cycles between lines
    localparam int num_tests = 6;
    localparam int timeout_cycles = 2 * num_tests * (h * (w + line_gap) + 80);

    logic                      clk;
    logic                      reset;
    logic                      reset_req;
    logic                      img_vsync;
    logic                      img_href;
    logic                      img_bit;
    logic                      region_valid;
    ccl_region_pkg::label_t    region_label;
    ccl_region_pkg::area_t     region_area;
    ccl_region_pkg::centroid_t centroid_x;
    ccl_region_pkg::centroid_t centroid_y;
    logic                      report_done;
    int                        checker_errors;
    int                        checker_reports;

    int          bench_errors;
    int          tests_run;
    int          err_mark;
    int          rep_mark;
    int          cycle_count;
    logic [31:0] rng;
    logic [w-1:0] image [h];        // image[y][x]

    tb_clock tb_clock_inst (
        .reset_req (reset_req),
        .clk       (clk),
        .reset     (reset)
    );

    ccl_centroid ccl_centroid_inst (
        .clk          (clk),
        .reset        (reset),
        .img_vsync    (img_vsync),
        .img_href     (img_href),
        .img_bit      (img_bit),
        .region_valid (region_valid),
        .region_label (region_label),
        .region_area  (region_area),
        .centroid_x   (centroid_x),
        .centroid_y   (centroid_y),
        .report_done  (report_done)
    );

    ccl_checker ccl_checker_inst (
        .clk          (clk),
        .reset        (reset),
        .img_vsync    (img_vsync),
        .img_href     (img_href),
        .img_bit      (img_bit),
        .region_valid (region_valid),
        .region_label (region_label),
        .region_area  (region_area),
        .centroid_x   (centroid_x),
        .centroid_y   (centroid_y),
        .report_done  (report_done),
        .error_count  (checker_errors),
        .report_count (checker_reports)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic int total_errors();
        return checker_errors + bench_errors + ccl_centroid_inst.ccl_props_inst.assert_fails;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // image setup
    ////////////////////////////////////////////////////////////////////////////

    task automatic clear_image();
        for (int y = 0; y < h; y++)
            image[y] = '0;
    endtask

    task automatic fill_rect(input int x0, input int y0, input int x1, input int y1);
        for (int y = y0; y <= y1; y++)
            for (int x = x0; x <= x1; x++)
                image[y][x] = 1'b1;
    endtask

    task automatic fill_random(input int percent);
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) begin
                rng = xorshift32(rng);
                image[y][x] = ((rng % 100) < percent);
            end
        end
    endtask

    // isolated pixels on even rows and columns
    task automatic fill_grid();
        for (int y = 0; y < h; y++)
            for (int x = 0; x < w; x++)
                image[y][x] = (x % 2 == 0) && (y % 2 == 0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // video driving, all changes on the falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_line(input int y, input int count);
        for (int x = 0; x < count; x++) begin
            img_href = 1'b1;
            img_bit  = image[y][x];
            @(negedge clk);
        end
        img_href = 1'b0;
        img_bit  = 1'b0;
    endtask

    task automatic drive_frame();
        int waited;
        img_vsync = 1'b1;
        repeat (2) @(negedge clk);
        for (int y = 0; y < h; y++) begin
            drive_line(y, w);
            repeat (line_gap) @(negedge clk);
        end
        img_vsync = 1'b0;
        waited = 0;
        while (!report_done) begin      // watchdog covers a missing done
            @(negedge clk);
            waited++;
        end
        while (waited < 80) begin       // minimum vsync low time
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic mark_test();
        err_mark = total_errors();
        rep_mark = checker_reports;
    endtask

    // want_reports < 0 leaves the count to the model
    task automatic finish_test(input string name, input int want_reports);
        int reps;
        reps = checker_reports - rep_mark;
        tests_run++;
        if (want_reports >= 0 && reps != want_reports) begin
            $display("test %0d %s expected %0d reports but saw %0d",
                     tests_run, name, want_reports, reps);
            bench_errors++;
        end
        $display("test %0d %s: %0d reports, %0d errors",
                 tests_run, name, reps, total_errors() - err_mark);
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the run did not finish", timeout_cycles);
        $display("Checks failed");
        $finish;
    end

    initial begin
        img_vsync    = 1'b0;
        img_href     = 1'b0;
        img_bit      = 1'b0;
        reset_req    = 1'b0;
        rng          = 32'd83303;
        bench_errors = 0;
        tests_run    = 0;
        clear_image();
        wait (reset === 1'b0);
        @(negedge clk);

        mark_test();
        clear_image();
        fill_rect(3, 4, 9, 10);
        drive_frame();
        finish_test("filled rectangle", 1);

        mark_test();
        clear_image();
        drive_frame();
        finish_test("empty frame", 0);

        mark_test();
        for (int f = 0; f < 3; f++) begin
            fill_random(30);
            drive_frame();
        end
        finish_test("random frames", -1);

        mark_test();
        fill_grid();
        drive_frame();
        finish_test("label overflow grid", ccl_region_pkg::max_labels);

        // second frame must not see the first one's sums
        mark_test();
        fill_random(30);
        drive_frame();
        clear_image();
        fill_rect(10, 1, 13, 5);
        drive_frame();
        finish_test("back to back frames", -1);

        // reset in the middle of line 8, then a clean frame
        mark_test();
        fill_random(30);
        img_vsync = 1'b1;
        repeat (2) @(negedge clk);
        for (int y = 0; y < 8; y++) begin
            drive_line(y, w);
            repeat (line_gap) @(negedge clk);
        end
        drive_line(8, 5);
        reset_req = 1'b1;
        img_vsync = 1'b0;
        repeat (2) @(negedge clk);
        reset_req = 1'b0;
        repeat (80) @(negedge clk);
        clear_image();
        fill_rect(0, 0, 5, 2);
        drive_frame();
        finish_test("reset mid frame", 1);

        $display("%0d tests, %0d reports checked, %0d errors",
                 tests_run, checker_reports, total_errors());
        if (total_errors() == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// ==== bench/ccl_props.sv ====
`timescale 1ns/1ps

module ccl_props (
    input logic                   clk,
    input logic                   reset,
    input logic                   img_vsync,
    input logic                   region_valid,
    input ccl_region_pkg::label_t region_label,
    input ccl_region_pkg::area_t  region_area,
    input logic                   report_done
);

    int                     assert_fails = 0;
    logic                   in_report;      // a region was already reported
    ccl_region_pkg::label_t last_label;

    always_ff @(posedge clk) begin
        if (reset || report_done) begin
            in_report <= 1'b0;
        end else if (region_valid) begin
            in_report  <= 1'b1;
            last_label <= region_label;
        end
    end

    area_nonzero: assert property (@(posedge clk) disable iff (reset)
        region_valid |-> (region_area != '0))
        else begin
            assert_fails++;
            $error("region_valid with zero area");
        end

    label_order: assert property (@(posedge clk) disable iff (reset)
        (region_valid && in_report) |-> (region_label > last_label))
        else begin
            assert_fails++;
            $error("region_label did not increase within a report");
        end

    quiet_in_frame: assert property (@(posedge clk) disable iff (reset)
        region_valid |-> !img_vsync)
        else begin
            assert_fails++;
            $error("region_valid while vsync is high");
        end

endmodule

bind ccl_centroid ccl_props ccl_props_inst (
    .clk          (clk),
    .reset        (reset),
    .img_vsync    (img_vsync),
    .region_valid (region_valid),
    .region_label (region_label),
    .region_area  (region_area),
    .report_done  (report_done)
);

// ==== bench/ccl_checker.sv ====
`timescale 1ns/1ps

module ccl_checker (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      img_vsync,
    input  logic                      img_href,
    input  logic                      img_bit,
    input  logic                      region_valid,
    input  ccl_region_pkg::label_t    region_label,
    input  ccl_region_pkg::area_t     region_area,
    input  ccl_region_pkg::centroid_t centroid_x,
    input  ccl_region_pkg::centroid_t centroid_y,
    input  logic                      report_done,
    output int                        error_count,
    output int                        report_count
);

    localparam int w     = ccl_frame_pkg::img_width;
    localparam int h     = ccl_frame_pkg::img_height;
    localparam int max_l = ccl_region_pkg::max_labels;

    logic pixels [h][w];            // last frame seen on the input
    int   model_labels [h][w];
    int   area [0:max_l];
    int   sum_x [0:max_l];
    int   sum_y [0:max_l];
    int   exp_queue [$];            // labels still to be reported
    int   col;
    int   row;
    logic vsync_q;
    logic href_q;
    logic frame_ready;

    initial begin
        error_count  = 0;
        report_count = 0;
        for (int y = 0; y < h; y++)
            for (int x = 0; x < w; x++)
                pixels[y][x] = 1'b0;
    end

    // label of an already seen pixel, 0 outside the image
    function automatic int label_at(input int x, input int y);
        if (x < 0 || x >= w || y < 0)
            return 0;
        return model_labels[y][x];
    endfunction

    function automatic int smaller_label(input int a, input int b);
        if (a == 0)
            return b;
        if (b == 0)
            return a;
        return (a < b) ? a : b;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // reference labeling of a whole frame
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_expected();
        int next_label;
        int best;
        exp_queue.delete();
        for (int l = 0; l <= max_l; l++) begin
            area[l]  = 0;
            sum_x[l] = 0;
            sum_y[l] = 0;
        end
        next_label = 1;
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) begin
                best = 0;
                if (pixels[y][x]) begin
                    best = smaller_label(label_at(x - 1, y), label_at(x - 1, y - 1));
                    best = smaller_label(best, label_at(x, y - 1));
                    best = smaller_label(best, label_at(x + 1, y - 1));
                    if (best == 0 && next_label <= max_l) begin
                        best = next_label;      // fresh region
                        next_label++;
                    end
                end
                model_labels[y][x] = best;      // 0 once labels run out
                if (best != 0) begin
                    area[best]++;
                    sum_x[best] += x;
                    sum_y[best] += y;
                end
            end
        end
        for (int l = 1; l <= max_l; l++)
            if (area[l] != 0)
                exp_queue.push_back(l);
    endtask

    task automatic compare(input string name, input int lab,
                           input logic [15:0] expected, input logic [15:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s for label %0d: expected %h, got %h", name, lab, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_region();
        int lab;
        report_count++;
        if (!frame_ready || exp_queue.size() == 0) begin
            $display("unexpected report for label %0d, no more regions were expected",
                     region_label);
            error_count++;
        end else begin
            lab = exp_queue.pop_front();
            compare("region_label", lab, 16'(lab), 16'(region_label));
            compare("region_area", lab, 16'(area[lab]), 16'(region_area));
            compare("centroid_x", lab,
                    16'((sum_x[lab] << ccl_region_pkg::frac_bits) / area[lab]),
                    16'(centroid_x));
            compare("centroid_y", lab,
                    16'((sum_y[lab] << ccl_region_pkg::frac_bits) / area[lab]),
                    16'(centroid_y));
        end
    endtask

    task automatic finish_report();
        if (!frame_ready) begin
            $display("report_done seen without a finished frame");
            error_count++;
        end else if (exp_queue.size() != 0) begin
            $display("report ended with %0d regions missing, first missing label %0d",
                     exp_queue.size(), exp_queue[0]);
            error_count++;
        end
        frame_ready = 1'b0;
        exp_queue.delete();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // watch inputs and outputs
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (reset) begin
            col         = 0;
            row         = 0;
            vsync_q     = 1'b0;
            href_q      = 1'b0;
            frame_ready = 1'b0;     // partial frame is dropped
            exp_queue.delete();
        end else begin
            if (img_vsync && img_href) begin
                if (row < h && col < w)
                    pixels[row][col] = img_bit;
                col++;
            end else begin
                col = 0;
            end
            if (!img_vsync)
                row = 0;
            else if (href_q && !img_href)
                row++;              // line ended
            if (vsync_q && !img_vsync) begin
                build_expected();
                frame_ready = 1'b1;
            end
            vsync_q = img_vsync;
            href_q  = img_href;

            if (region_valid)
                check_region();
            if (report_done)
                finish_report();
        end
    end

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    input  logic reset_req,    // extra reset from the test sequence
    output logic clk,
    output logic reset
);

    logic por;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;     // 40 ns period
    end

    // power-on reset over the first two rising edges
    initial begin
        por = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        por = 1'b0;
    end

    assign reset = por | reset_req;

endmodule

// ==== rtl/ccl_centroid.sv ====
`timescale 1ns/1ps

module ccl_centroid (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      img_vsync,
    input  logic                      img_href,
    input  logic                      img_bit,
    output logic                      region_valid,
    output ccl_region_pkg::label_t    region_label,
    output ccl_region_pkg::area_t     region_area,
    output ccl_region_pkg::centroid_t centroid_x,
    output ccl_region_pkg::centroid_t centroid_y,
    output logic                      report_done
);

    logic                   pix_valid;
    logic                   pix_bit;
    ccl_frame_pkg::coord_t  pix_x;
    ccl_frame_pkg::coord_t  pix_y;
    logic                   frame_end;
    logic                   acc_en;
    ccl_region_pkg::label_t acc_label;
    ccl_frame_pkg::coord_t  acc_x;
    ccl_frame_pkg::coord_t  acc_y;
    logic                   rd_en;
    ccl_region_pkg::label_t rd_addr;
    ccl_region_pkg::area_t  area_rd;
    ccl_region_pkg::sum_t   sum_x_rd;
    ccl_region_pkg::sum_t   sum_y_rd;

    frame_timing frame_timing_inst (
        .clk       (clk),
        .reset     (reset),
        .img_vsync (img_vsync),
        .img_href  (img_href),
        .img_bit   (img_bit),
        .pix_valid (pix_valid),
        .pix_bit   (pix_bit),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .frame_end (frame_end)
    );

    label_assigner label_assigner_inst (
        .clk       (clk),
        .reset     (reset),
        .pix_valid (pix_valid),
        .pix_bit   (pix_bit),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .acc_en    (acc_en),
        .acc_label (acc_label),
        .acc_x     (acc_x),
        .acc_y     (acc_y)
    );

    ////////////////////////////////////////////////////////////////////////////
    // per-label statistics
    ////////////////////////////////////////////////////////////////////////////

    region_accumulator #(.payload_t(ccl_region_pkg::area_t)) area_acc_inst (
        .clk       (clk),
        .reset     (reset),
        .acc_en    (acc_en),
        .acc_label (acc_label),
        .increment (ccl_region_pkg::area_t'(1)),   // one pixel
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (area_rd)
    );

    region_accumulator #(.payload_t(ccl_region_pkg::sum_t)) sum_x_acc_inst (
        .clk       (clk),
        .reset     (reset),
        .acc_en    (acc_en),
        .acc_label (acc_label),
        .increment (ccl_region_pkg::sum_t'(acc_x)),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (sum_x_rd)
    );

    region_accumulator #(.payload_t(ccl_region_pkg::sum_t)) sum_y_acc_inst (
        .clk       (clk),
        .reset     (reset),
        .acc_en    (acc_en),
        .acc_label (acc_label),
        .increment (ccl_region_pkg::sum_t'(acc_y)),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (sum_y_rd)
    );

    centroid_reporter centroid_reporter_inst (
        .clk          (clk),
        .reset        (reset),
        .frame_end    (frame_end),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .area_in      (area_rd),
        .sum_x_in     (sum_x_rd),
        .sum_y_in     (sum_y_rd),
        .region_valid (region_valid),
        .region_label (region_label),
        .region_area  (region_area),
        .centroid_x   (centroid_x),
        .centroid_y   (centroid_y),
        .report_done  (report_done)
    );

endmodule

// ==== rtl/centroid_reporter.sv ====
`timescale 1ns/1ps

module centroid_reporter (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      frame_end,
    output logic                      rd_en,
    output ccl_region_pkg::label_t    rd_addr,
    input  ccl_region_pkg::area_t     area_in,
    input  ccl_region_pkg::sum_t      sum_x_in,
    input  ccl_region_pkg::sum_t      sum_y_in,
    output logic                      region_valid,
    output ccl_region_pkg::label_t    region_label,
    output ccl_region_pkg::area_t     region_area,
    output ccl_region_pkg::centroid_t centroid_x,
    output ccl_region_pkg::centroid_t centroid_y,
    output logic                      report_done
);

    logic                   start_q;
    logic                   rd_q;       // accumulator data valid this cycle
    logic                   last_q;
    logic                   last_qq;
    ccl_region_pkg::label_t label_q;

    // floor(sum * 2^frac_bits / area)
    function automatic ccl_region_pkg::centroid_t scale_div(
        input ccl_region_pkg::sum_t  sum,
        input ccl_region_pkg::area_t area
    );
        logic [$bits(ccl_region_pkg::sum_t)+ccl_region_pkg::frac_bits-1:0] num;
        num = {sum, {ccl_region_pkg::frac_bits{1'b0}}};
        if (area == '0)
            return '0;
        return ccl_region_pkg::centroid_t'(num / area);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // label scan
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            start_q      <= 1'b0;
            rd_en        <= 1'b0;
            rd_addr      <= '0;
            rd_q         <= 1'b0;
            last_q       <= 1'b0;
            last_qq      <= 1'b0;
            region_valid <= 1'b0;
            report_done  <= 1'b0;
        end else begin
            start_q <= frame_end;
            if (start_q) begin
                rd_en   <= 1'b1;
                rd_addr <= ccl_region_pkg::label_t'(1);
            end else if (rd_en) begin
                if (rd_addr == ccl_region_pkg::label_t'(ccl_region_pkg::max_labels)) begin
                    rd_en   <= 1'b0;
                    rd_addr <= '0;
                end else begin
                    rd_addr <= rd_addr + 1'b1;
                end
            end

            rd_q    <= rd_en;
            last_q  <= rd_en && (rd_addr == ccl_region_pkg::label_t'(ccl_region_pkg::max_labels));
            last_qq <= last_q;
            report_done <= last_qq;

            region_valid <= rd_q && (area_in != '0);   // empty labels skipped
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // divide
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        label_q <= rd_addr;
        if (rd_q) begin
            region_label <= label_q;
            region_area  <= area_in;
            centroid_x   <= scale_div(sum_x_in, area_in);
            centroid_y   <= scale_div(sum_y_in, area_in);
        end
    end

endmodule

// ==== rtl/region_accumulator.sv ====
`timescale 1ns/1ps

module region_accumulator #(
    parameter type payload_t = logic [7:0]
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   acc_en,
    input  ccl_region_pkg::label_t acc_label,
    input  payload_t               increment,
    input  logic                   rd_en,
    input  ccl_region_pkg::label_t rd_addr,
    output payload_t               rd_data
);

    payload_t                             mem [1:ccl_region_pkg::max_labels];
    logic [ccl_region_pkg::max_labels:1]  occupied;    // entry written this frame

    // read stage
    logic                   s1_valid;
    ccl_region_pkg::label_t s1_label;
    payload_t               s1_inc;
    payload_t               s1_base;

    // forward cache, new is being written this cycle, old was written last cycle
    logic                   new_valid;
    ccl_region_pkg::label_t new_label;
    payload_t               new_data;
    logic                   old_valid;
    ccl_region_pkg::label_t old_label;
    payload_t               old_data;

    payload_t base;
    payload_t sum;

    always_comb begin
        if (new_valid && new_label == s1_label)
            base = new_data;
        else if (old_valid && old_label == s1_label)
            base = old_data;
        else
            base = s1_base;
        sum = base + s1_inc;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            new_valid <= 1'b0;
            old_valid <= 1'b0;
            occupied  <= '0;
        end else begin
            s1_valid  <= acc_en;
            new_valid <= s1_valid;
            old_valid <= new_valid;
            if (new_valid)
                occupied[new_label] <= 1'b1;
            if (rd_en)
                occupied[rd_addr] <= 1'b0;  // read-clear wins
        end
    end

    always_ff @(posedge clk) begin
        s1_label  <= acc_label;
        s1_inc    <= increment;
        if (acc_en)
            s1_base <= occupied[acc_label] ? mem[acc_label] : '0;

        new_label <= s1_label;
        new_data  <= sum;
        old_label <= new_label;
        old_data  <= new_data;

        if (new_valid)
            mem[new_label] <= new_data;

        if (rd_en) begin
            if (new_valid && new_label == rd_addr)
                rd_data <= new_data;            // write in flight
            else if (occupied[rd_addr])
                rd_data <= mem[rd_addr];
            else
                rd_data <= '0;
        end
    end

endmodule

// ==== labeling/label_assigner.sv ====
`timescale 1ns/1ps

module label_assigner (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   pix_valid,
    input  logic                   pix_bit,
    input  ccl_frame_pkg::coord_t  pix_x,
    input  ccl_frame_pkg::coord_t  pix_y,
    output logic                   acc_en,
    output ccl_region_pkg::label_t acc_label,
    output ccl_frame_pkg::coord_t  acc_x,
    output ccl_frame_pkg::coord_t  acc_y
);

    ccl_region_pkg::label_t next_label;    // 0 once the labels are used up
    ccl_region_pkg::label_t avail_label;
    ccl_region_pkg::label_t ur_raw;        // previous row, column pix_x+1
    ccl_region_pkg::label_t up_q;
    ccl_region_pkg::label_t ul_q;
    ccl_region_pkg::label_t col0_q;        // previous row, column 0
    ccl_region_pkg::label_t up_cur;
    ccl_region_pkg::label_t left_n;
    ccl_region_pkg::label_t ul_n;
    ccl_region_pkg::label_t up_n;
    ccl_region_pkg::label_t ur_n;
    ccl_region_pkg::label_t best;
    ccl_region_pkg::label_t cur_label;
    ccl_frame_pkg::coord_t  next_x;
    ccl_frame_pkg::coord_t  rd_addr;
    logic                   top_row;
    logic                   left_edge;
    logic                   right_edge;
    logic                   need_new;

    // smallest non-zero of two labels, 0 if both are 0
    function automatic ccl_region_pkg::label_t min_nz(
        input ccl_region_pkg::label_t a,
        input ccl_region_pkg::label_t b
    );
        if (a == '0)
            return b;
        if (b == '0)
            return a;
        return (a < b) ? a : b;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // previous row window
    ////////////////////////////////////////////////////////////////////////////

    // fetch up-right of the next pixel a cycle early; idle cycles
    // before a line prime column 1
    assign next_x  = pix_valid ? pix_x + 1'b1 : '0;
    assign rd_addr = next_x + 1'b1;

    line_label_buffer line_label_buffer_inst (
        .clk     (clk),
        .wr_en   (pix_valid),
        .wr_addr (pix_x),
        .rd_addr (rd_addr),
        .wr_data (cur_label),
        .rd_data (ur_raw)
    );

    ////////////////////////////////////////////////////////////////////////////
    // label choice
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        top_row    = (pix_y == '0);
        left_edge  = (pix_x == '0);
        right_edge = (pix_x == ccl_frame_pkg::coord_t'(ccl_frame_pkg::img_width - 1));

        up_cur = left_edge ? col0_q : up_q;

        // outside the image counts as background
        left_n = left_edge ? '0 : acc_label;
        ul_n   = (top_row || left_edge) ? '0 : ul_q;
        up_n   = top_row ? '0 : up_cur;
        ur_n   = (top_row || right_edge) ? '0 : ur_raw;

        best = min_nz(min_nz(left_n, ul_n), min_nz(up_n, ur_n));

        // numbering restarts at the first pixel of a frame
        avail_label = (top_row && left_edge) ? ccl_region_pkg::label_t'(1) : next_label;
        need_new    = pix_bit && (best == '0);

        if (!pix_bit)
            cur_label = '0;
        else if (best != '0)
            cur_label = best;
        else
            cur_label = avail_label;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc_en     <= 1'b0;
            next_label <= ccl_region_pkg::label_t'(1);
        end else begin
            acc_en <= pix_valid && (cur_label != '0);
            if (pix_valid) begin
                if (need_new && avail_label != '0) begin
                    if (avail_label == ccl_region_pkg::label_t'(ccl_region_pkg::max_labels))
                        next_label <= '0;               // exhausted
                    else
                        next_label <= avail_label + 1'b1;
                end else begin
                    next_label <= avail_label;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pix_valid) begin
            acc_label <= cur_label;     // also the left neighbour
            acc_x     <= pix_x;
            acc_y     <= pix_y;
            up_q      <= ur_raw;        // shift window by one column
            ul_q      <= up_cur;
            if (left_edge)
                col0_q <= cur_label;
        end
    end

endmodule

// ==== labeling/line_label_buffer.sv ====
`timescale 1ns/1ps

module line_label_buffer (
    input  logic                   clk,
    input  logic                   wr_en,
    input  ccl_frame_pkg::coord_t  wr_addr,
    input  ccl_frame_pkg::coord_t  rd_addr,
    input  ccl_region_pkg::label_t wr_data,
    output ccl_region_pkg::label_t rd_data
);

    // one label per column; the current row overwrites the previous one
    // behind the read pointer
    ccl_region_pkg::label_t mem [ccl_frame_pkg::img_width];

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        rd_data <= mem[rd_addr];    // registered read
    end

endmodule

// ==== rtl/frame_timing.sv ====
`timescale 1ns/1ps

module frame_timing (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  img_vsync,
    input  logic                  img_href,
    input  logic                  img_bit,
    output logic                  pix_valid,
    output logic                  pix_bit,
    output ccl_frame_pkg::coord_t pix_x,
    output ccl_frame_pkg::coord_t pix_y,
    output logic                  frame_end
);

    logic                  vsync_q;
    logic                  href_q;
    ccl_frame_pkg::coord_t col_cnt;    // column of the pixel now on the input
    ccl_frame_pkg::coord_t row_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            vsync_q   <= 1'b0;
            href_q    <= 1'b0;
            col_cnt   <= '0;
            row_cnt   <= '0;
            pix_valid <= 1'b0;
            frame_end <= 1'b0;
        end else begin
            vsync_q   <= img_vsync;
            href_q    <= img_href;
            pix_valid <= img_vsync & img_href;
            frame_end <= vsync_q & ~img_vsync;     // vsync fall

            if (img_vsync && img_href)
                col_cnt <= col_cnt + 1'b1;
            else
                col_cnt <= '0;

            // next row starts after each href fall
            if (!img_vsync)
                row_cnt <= '0;
            else if (href_q && !img_href)
                row_cnt <= row_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        pix_bit <= img_bit;
        pix_x   <= col_cnt;
        pix_y   <= row_cnt;
    end

endmodule

// ==== common/ccl_region_pkg.sv ====
package ccl_region_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // label space
    ////////////////////////////////////////////////////////////////////////////

    localparam int max_labels = 31;     // highest label handed out
    localparam int label_w    = 5;

    typedef logic [label_w-1:0] label_t;    // 0 is background

    ////////////////////////////////////////////////////////////////////////////
    // per-region statistics
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [8:0]  area_t;        // up to a full 16x16 frame
    typedef logic [12:0] sum_t;         // sum of column or row numbers

    // centroid is 4 integer bits and 5 fraction bits
    localparam int frac_bits = 5;

    typedef logic [8:0] centroid_t;

endpackage

// ==== common/ccl_frame_pkg.sv ====
package ccl_frame_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // frame geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int img_width  = 16;     // pixels per line
    localparam int img_height = 16;     // lines per frame

    // wide enough for any column or row of the frame
    localparam int coord_w = 4;

    typedef logic [coord_w-1:0] coord_t;

endpackage
